// File: verilog/fsq_settings.svh
`ifndef FSQ_SETTINGS_SVH
`define FSQ_SETTINGS_SVH

// queue geometry
`define FSQ_DEPTH 16
`define FSQ_IDX_W 4

// stream fields
`define VADDR_W 32
// offset of last instruction in a 16-instruction block
`define SIZE_W 4

// commit side
`define COMMIT_NUM_W 3
`define CNT_W 6

`endif

// File: verilog/fsq_pkg.sv
`include "fsq_settings.svh"

package fsq_pkg;

    // wrap bit on top, slot index below
    typedef struct packed {
        logic dir;
        logic [`FSQ_IDX_W-1:0] idx;
    } fsq_ptr_fld_t;

    // raw view counts through both wraps, so +1 flips dir on its own
    typedef union packed {
        logic [`FSQ_IDX_W:0] raw;
        fsq_ptr_fld_t fld;
    } fsq_ptr_u;

    // one predicted fetch stream
    typedef struct packed {
        logic [`VADDR_W-1:0] start_addr;
        logic [`VADDR_W-1:0] target;
        logic [`SIZE_W-1:0] size;
    } fetch_stream_t;

endpackage

// File: verilog/fsq_ptr_if.sv
`timescale 1ns/1ps

interface fsq_ptr_if;
    import fsq_pkg::*;

    // queue pointers
    fsq_ptr_u tail;
    fsq_ptr_u search;
    fsq_ptr_u commit;

    // write controls from the tail side
    logic push;
    logic redir_en;
    fsq_ptr_u redir_ptr;

    modport tail_mp (
        output tail,
        output push,
        output redir_en,
        output redir_ptr,
        input commit
    );

    modport issue_mp (
        output search,
        input tail,
        input redir_en,
        input redir_ptr
    );

    modport commit_mp (
        output commit,
        input tail
    );

    modport ram_mp (
        input tail,
        input search,
        input commit,
        input push,
        input redir_en,
        input redir_ptr
    );

endinterface

// File: verilog/fsq_stream_ram.sv
`timescale 1ns/1ps
`include "fsq_settings.svh"

module fsq_stream_ram (
    input logic clk,
    input logic rst,
    fsq_ptr_if.ram_mp ptr,
    input fsq_pkg::fetch_stream_t wdata,
    input logic [`SIZE_W-1:0] redir_offset,
    input logic [`VADDR_W-1:0] redir_target,
    output fsq_pkg::fetch_stream_t search_stream,
    output fsq_pkg::fetch_stream_t commit_stream
);
    import fsq_pkg::*;

    fetch_stream_t mem [`FSQ_DEPTH];

    // redirect truncates the slot in place, start address kept
    always_ff @(posedge clk) begin
        if (ptr.redir_en) begin
            mem[ptr.redir_ptr.fld.idx].size <= redir_offset;
            mem[ptr.redir_ptr.fld.idx].target <= redir_target;
        end else if (ptr.push) begin
            mem[ptr.tail.fld.idx] <= wdata;
        end
    end

    // cache side and commit side read ports
    assign search_stream = mem[ptr.search.fld.idx];
    assign commit_stream = mem[ptr.commit.fld.idx];

    // tail side never issues both writes together
    a_single_write: assert property (
        @(posedge clk) disable iff (rst)
        !(ptr.push && ptr.redir_en)
    );

endmodule

// File: verilog/fsq_fetch_issue.sv
`timescale 1ns/1ps
`include "fsq_settings.svh"

module fsq_fetch_issue (
    input logic clk,
    input logic rst,
    fsq_ptr_if.issue_mp ptr,
    input logic cache_ready,
    output logic cache_valid,
    output logic [`FSQ_IDX_W-1:0] cache_idx
);
    import fsq_pkg::*;

    fsq_ptr_u search_q;
    logic accept;
    logic [`FSQ_IDX_W:0] issue_gap;

    // anything between search head and tail is waiting for the cache
    assign cache_valid = (search_q.raw != ptr.tail.raw) && !ptr.redir_en;
    assign accept = cache_valid && cache_ready;
    assign cache_idx = search_q.fld.idx;
    assign ptr.search = search_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            search_q <= '0;
        end else if (ptr.redir_en) begin
            // restart just past the redirected slot
            search_q.raw <= ptr.redir_ptr.raw + 1'b1;
        end else if (accept) begin
            search_q.raw <= search_q.raw + 1'b1;
        end
    end

    // streams still to be issued
    assign issue_gap = ptr.tail.raw - search_q.raw;

    a_search_behind_tail: assert property (
        @(posedge clk) disable iff (rst)
        issue_gap <= `FSQ_DEPTH
    );

endmodule

// File: verilog/fsq_commit_track.sv
`timescale 1ns/1ps
`include "fsq_settings.svh"

module fsq_commit_track (
    input logic clk,
    input logic rst,
    fsq_ptr_if.commit_mp ptr,
    input logic [`COMMIT_NUM_W-1:0] commit_num,
    input fsq_pkg::fetch_stream_t commit_stream,
    output logic update,
    output logic [`VADDR_W-1:0] update_start_addr,
    output logic [`VADDR_W-1:0] update_target
);
    import fsq_pkg::*;

    fsq_ptr_u commit_q;
    logic [`CNT_W-1:0] pend_cnt;
    logic [`CNT_W-1:0] head_size;
    logic [`CNT_W-1:0] retire_num;
    logic retire;
    // extra top bit catches overflow
    logic [`CNT_W:0] pend_next;

    assign head_size = {{(`CNT_W-`SIZE_W){1'b0}}, commit_stream.size};

    // head stream done once more than size instructions have committed
    assign retire = (pend_cnt > head_size) && (commit_q.raw != ptr.tail.raw);
    assign retire_num = retire ? head_size + 1'b1 : '0;

    assign pend_next = {1'b0, pend_cnt} - {1'b0, retire_num}
                     + {{(`CNT_W+1-`COMMIT_NUM_W){1'b0}}, commit_num};

    assign ptr.commit = commit_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_q <= '0;
            pend_cnt <= '0;
            update <= 1'b0;
        end else begin
            pend_cnt <= pend_next[`CNT_W-1:0];
            update <= retire;
            if (retire) begin
                commit_q.raw <= commit_q.raw + 1'b1;
            end
        end
    end

    // predictor update payload
    always_ff @(posedge clk) begin
        if (retire) begin
            update_start_addr <= commit_stream.start_addr;
            update_target <= commit_stream.target;
        end
    end

    a_pend_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        !pend_next[`CNT_W]
    );

endmodule

// File: verilog/fsq_tail_ctrl.sv
`timescale 1ns/1ps
`include "fsq_settings.svh"

module fsq_tail_ctrl (
    input logic clk,
    input logic rst,
    fsq_ptr_if.tail_mp ptr,
    input logic pred_valid,
    input logic redirect_valid,
    input logic [`FSQ_IDX_W-1:0] redirect_idx,
    input logic [`VADDR_W-1:0] redirect_target,
    output logic pred_stall,
    output logic [`FSQ_IDX_W-1:0] pred_idx,
    output logic squash,
    output logic [`VADDR_W-1:0] squash_target
);
    import fsq_pkg::*;

    fsq_ptr_u tail_q;
    fsq_ptr_u redir_ptr;
    logic full;
    logic [`FSQ_IDX_W:0] occupancy;

    // same slot, opposite lap
    assign full = (tail_q.fld.idx == ptr.commit.fld.idx)
               && (tail_q.fld.dir != ptr.commit.fld.dir);
    assign pred_stall = full;
    assign pred_idx = tail_q.fld.idx;

    // predictor writes lose to a redirect
    assign ptr.push = pred_valid && !full && !redirect_valid;
    assign ptr.redir_en = redirect_valid;

    // slot below the commit index has already wrapped
    always_comb begin
        redir_ptr.fld.idx = redirect_idx;
        redir_ptr.fld.dir = (redirect_idx >= ptr.commit.fld.idx) ?
                            ptr.commit.fld.dir : !ptr.commit.fld.dir;
    end

    assign ptr.redir_ptr = redir_ptr;
    assign ptr.tail = tail_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail_q <= '0;
            squash <= 1'b0;
        end else begin
            squash <= redirect_valid;
            if (redirect_valid) begin
                tail_q.raw <= redir_ptr.raw + 1'b1;
            end else if (ptr.push) begin
                tail_q.raw <= tail_q.raw + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_valid) begin
            squash_target <= redirect_target;
        end
    end

    // no push while full keeps live streams within the queue
    assign occupancy = tail_q.raw - ptr.commit.raw;

    a_no_overfill: assert property (
        @(posedge clk) disable iff (rst)
        occupancy <= `FSQ_DEPTH
    );

endmodule

// File: verilog/fsq_top.sv
`timescale 1ns/1ps
`include "fsq_settings.svh"

module fsq_top (
    input logic clk,
    input logic rst,
    // predictor push
    input logic pred_valid,
    input logic [`VADDR_W-1:0] pred_start_addr,
    input logic [`VADDR_W-1:0] pred_target,
    input logic [`SIZE_W-1:0] pred_size,
    output logic pred_stall,
    output logic [`FSQ_IDX_W-1:0] pred_idx,
    // cache request
    input logic cache_ready,
    output logic cache_valid,
    output logic [`FSQ_IDX_W-1:0] cache_idx,
    output logic [`VADDR_W-1:0] cache_start_addr,
    output logic [`VADDR_W-1:0] cache_target,
    output logic [`SIZE_W-1:0] cache_size,
    // backend redirect and commit
    input logic redirect_valid,
    input logic [`FSQ_IDX_W-1:0] redirect_idx,
    input logic [`SIZE_W-1:0] redirect_offset,
    input logic [`VADDR_W-1:0] redirect_target,
    input logic [`COMMIT_NUM_W-1:0] commit_num,
    // predictor feedback
    output logic squash,
    output logic [`VADDR_W-1:0] squash_target,
    output logic update,
    output logic [`VADDR_W-1:0] update_start_addr,
    output logic [`VADDR_W-1:0] update_target
);
    import fsq_pkg::*;

    fetch_stream_t pred_stream;
    fetch_stream_t search_stream;
    fetch_stream_t commit_stream;

    assign pred_stream.start_addr = pred_start_addr;
    assign pred_stream.target = pred_target;
    assign pred_stream.size = pred_size;

    assign cache_start_addr = search_stream.start_addr;
    assign cache_target = search_stream.target;
    assign cache_size = search_stream.size;

    fsq_ptr_if ptr_bus ();

    fsq_stream_ram i_stream_ram (
        .clk           (clk),
        .rst           (rst),
        .ptr           (ptr_bus.ram_mp),
        .wdata         (pred_stream),
        .redir_offset  (redirect_offset),
        .redir_target  (redirect_target),
        .search_stream (search_stream),
        .commit_stream (commit_stream)
    );

    fsq_fetch_issue i_fetch_issue (
        .clk         (clk),
        .rst         (rst),
        .ptr         (ptr_bus.issue_mp),
        .cache_ready (cache_ready),
        .cache_valid (cache_valid),
        .cache_idx   (cache_idx)
    );

    fsq_commit_track i_commit_track (
        .clk               (clk),
        .rst               (rst),
        .ptr               (ptr_bus.commit_mp),
        .commit_num        (commit_num),
        .commit_stream     (commit_stream),
        .update            (update),
        .update_start_addr (update_start_addr),
        .update_target     (update_target)
    );

    fsq_tail_ctrl i_tail_ctrl (
        .clk             (clk),
        .rst             (rst),
        .ptr             (ptr_bus.tail_mp),
        .pred_valid      (pred_valid),
        .redirect_valid  (redirect_valid),
        .redirect_idx    (redirect_idx),
        .redirect_target (redirect_target),
        .pred_stall      (pred_stall),
        .pred_idx        (pred_idx),
        .squash          (squash),
        .squash_target   (squash_target)
    );

endmodule

// File: test/fsq_tb_checks.svh
// reference model of the queue, stepped once per table row
fsq_ptr_u m_tail = '0;
fsq_ptr_u m_search = '0;
fsq_ptr_u m_commit = '0;
int m_pend = 0;
fetch_stream_t m_mem [`FSQ_DEPTH];
logic m_squash = 1'b0;
logic [`VADDR_W-1:0] m_squash_target;
logic m_update = 1'b0;
fetch_stream_t m_retired;

int n_checks = 0;
int n_errors = 0;
int test_checks = 0;
int test_errors = 0;

task automatic count_result(input bit ok);
    n_checks++;
    test_checks++;
    if (!ok) begin
        n_errors++;
        test_errors++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    count_result(got === exp);
    if (got !== exp) begin
        $display("ERROR %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_ptr(input string name, input logic [`FSQ_IDX_W-1:0] got,
                         input fsq_ptr_u exp);
    count_result(got === exp.fld.idx);
    if (got !== exp.fld.idx) begin
        $display("ERROR %s: got 0x%h expected 0x%h at %0t", name, got, exp.fld.idx, $time);
    end
endtask

task automatic check_addr(input string name, input logic [`VADDR_W-1:0] got,
                          input logic [`VADDR_W-1:0] exp);
    count_result(got === exp);
    if (got !== exp) begin
        $display("ERROR %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_stream(input string name, input fetch_stream_t got,
                            input fetch_stream_t exp);
    count_result(got === exp);
    if (got !== exp) begin
        $display("ERROR %s: got 0x%h/0x%h/0x%h expected 0x%h/0x%h/0x%h at %0t", name,
                 got.start_addr, got.target, got.size,
                 exp.start_addr, exp.target, exp.size, $time);
    end
endtask

// same slot, opposite lap
function automatic logic full_now();
    return (m_tail.fld.idx == m_commit.fld.idx) && (m_tail.fld.dir != m_commit.fld.dir);
endfunction

task automatic check_outputs(input row_t r);
    fetch_stream_t got;
    logic exp_valid;
    exp_valid = (m_search.raw != m_tail.raw) && !r.redirect_valid;
    check_bit("pred_stall", pred_stall, full_now());
    check_ptr("pred_idx", pred_idx, m_tail);
    check_bit("cache_valid", cache_valid, exp_valid);
    if (exp_valid) begin
        got = {cache_start_addr, cache_target, cache_size};
        check_ptr("cache_idx", cache_idx, m_search);
        check_stream("cache_stream", got, m_mem[m_search.fld.idx]);
    end
    check_bit("squash", squash, m_squash);
    if (m_squash) begin
        check_addr("squash_target", squash_target, m_squash_target);
    end
    check_bit("update", update, m_update);
    if (m_update) begin
        check_addr("update_start_addr", update_start_addr, m_retired.start_addr);
        check_addr("update_target", update_target, m_retired.target);
    end
endtask

// next state after the edge that samples row r
task automatic model_step(input row_t r);
    logic full;
    logic issue;
    logic retire;
    fsq_ptr_u rptr;
    full = full_now();
    issue = (m_search.raw != m_tail.raw) && !r.redirect_valid && r.cache_ready;
    retire = (m_pend > int'(m_mem[m_commit.fld.idx].size)) && (m_commit.raw != m_tail.raw);
    // slot below the commit head belongs to the next lap
    rptr.fld.idx = r.redirect_idx;
    rptr.fld.dir = (r.redirect_idx >= m_commit.fld.idx) ? m_commit.fld.dir
                                                        : !m_commit.fld.dir;
    m_update = retire;
    m_squash = r.redirect_valid;
    if (retire) begin
        m_retired = m_mem[m_commit.fld.idx];
        m_pend -= int'(m_retired.size) + 1;
        m_commit.raw = m_commit.raw + 1'b1;
    end
    m_pend += int'(r.commit_num);
    if (r.redirect_valid) begin
        m_mem[r.redirect_idx].size = r.redirect_offset;
        m_mem[r.redirect_idx].target = r.redirect_target;
        m_squash_target = r.redirect_target;
        m_tail.raw = rptr.raw + 1'b1;
        m_search.raw = rptr.raw + 1'b1;
    end else begin
        if (r.pred_valid && !full) begin
            m_mem[m_tail.fld.idx] = r.stream;
            m_tail.raw = m_tail.raw + 1'b1;
        end
        if (issue) begin
            m_search.raw = m_search.raw + 1'b1;
        end
    end
endtask

task automatic report_test(input int id);
    $display("test %0d (%s): %0d checks, %0d errors",
             id, test_names[id-1], test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
endtask

// File: test/fsq_tb.sv
`timescale 1ns/1ps
`include "fsq_settings.svh"

module fsq_tb;
    import fsq_pkg::*;

    typedef struct {
        int test;
        logic pred_valid;
        fetch_stream_t stream;
        logic cache_ready;
        logic redirect_valid;
        logic [`FSQ_IDX_W-1:0] redirect_idx;
        logic [`SIZE_W-1:0] redirect_offset;
        logic [`VADDR_W-1:0] redirect_target;
        logic [`COMMIT_NUM_W-1:0] commit_num;
    } row_t;

    logic clk;
    logic rst;
    logic pred_valid;
    logic [`VADDR_W-1:0] pred_start_addr;
    logic [`VADDR_W-1:0] pred_target;
    logic [`SIZE_W-1:0] pred_size;
    logic pred_stall;
    logic [`FSQ_IDX_W-1:0] pred_idx;
    logic cache_ready;
    logic cache_valid;
    logic [`FSQ_IDX_W-1:0] cache_idx;
    logic [`VADDR_W-1:0] cache_start_addr;
    logic [`VADDR_W-1:0] cache_target;
    logic [`SIZE_W-1:0] cache_size;
    logic redirect_valid;
    logic [`FSQ_IDX_W-1:0] redirect_idx;
    logic [`SIZE_W-1:0] redirect_offset;
    logic [`VADDR_W-1:0] redirect_target;
    logic [`COMMIT_NUM_W-1:0] commit_num;
    logic squash;
    logic [`VADDR_W-1:0] squash_target;
    logic update;
    logic [`VADDR_W-1:0] update_start_addr;
    logic [`VADDR_W-1:0] update_target;

    row_t rows [$];
    bit rows_ready = 1'b0;
    logic [31:0] lfsr_state = 32'hc583;
    string test_names [5] = '{"push order", "cache back-pressure", "queue full",
                              "commit and update", "redirect and squash"};

    // stream sizes, the last two of the full test are refused pushes
    logic [`SIZE_W-1:0] t1_sizes [4] = '{2, 0, 5, 3};
    logic [`SIZE_W-1:0] t2_sizes [3] = '{1, 4, 2};
    logic [`SIZE_W-1:0] t3_sizes [11] = '{3, 1, 6, 0, 2, 7, 1, 4, 2, 5, 5};

    `include "fsq_tb_checks.svh"

    fsq_top i_fsq_top (.*);

    always #50 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int b = 0; b < n; b++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic add_row(input int test, input logic pv, input logic [`SIZE_W-1:0] size,
                           input logic cr, input logic rv,
                           input logic [`FSQ_IDX_W-1:0] ridx,
                           input logic [`COMMIT_NUM_W-1:0] cn);
        row_t r;
        r.test = test;
        r.pred_valid = pv;
        r.stream.start_addr = rand_bits(32);
        r.stream.target = rand_bits(32);
        r.stream.size = size;
        r.cache_ready = cr;
        r.redirect_valid = rv;
        r.redirect_idx = ridx;
        // truncate to the first instruction of the stream
        r.redirect_offset = '0;
        r.redirect_target = rand_bits(32);
        r.commit_num = cn;
        rows.push_back(r);
    endtask

    task automatic build_table();
        foreach (t1_sizes[i]) begin
            add_row(1, 1'b1, t1_sizes[i], 1'b1, 1'b0, 0, 0);
        end
        repeat (2) add_row(1, 1'b0, 0, 1'b1, 1'b0, 0, 0);
        foreach (t2_sizes[i]) begin
            add_row(2, 1'b1, t2_sizes[i], 1'b0, 1'b0, 0, 0);
        end
        repeat (3) add_row(2, 1'b0, 0, 1'b0, 1'b0, 0, 0);
        repeat (3) add_row(2, 1'b0, 0, 1'b1, 1'b0, 0, 0);
        foreach (t3_sizes[i]) begin
            add_row(3, 1'b1, t3_sizes[i], 1'b1, 1'b0, 0, 0);
        end
        repeat (3) add_row(4, 1'b0, 0, 1'b1, 1'b0, 0, 7);
        repeat (3) add_row(4, 1'b0, 0, 1'b1, 1'b0, 0, 0);
        // redirect at slot 13, then two new streams behind it
        add_row(5, 1'b0, 0, 1'b1, 1'b1, 13, 0);
        add_row(5, 1'b0, 0, 1'b1, 1'b0, 0, 0);
        add_row(5, 1'b1, 3, 1'b1, 1'b0, 0, 0);
        add_row(5, 1'b1, 2, 1'b1, 1'b0, 0, 0);
        repeat (5) add_row(5, 1'b0, 0, 1'b1, 1'b0, 0, 7);
        // last stream retires only if slot 13 was truncated
        add_row(5, 1'b0, 0, 1'b1, 1'b0, 0, 1);
        repeat (9) add_row(5, 1'b0, 0, 1'b1, 1'b0, 0, 0);
    endtask

    // rows plus reset plus margin, 100 ns per cycle
    initial begin
        wait (rows_ready);
        #((rows.size() + 8 + 20) * 100);
        $display("timeout: stimulus table did not finish in the expected time");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int cur_test;
        clk = 1'b0;
        rst = 1'b1;
        pred_valid = 1'b0;
        pred_start_addr = '0;
        pred_target = '0;
        pred_size = '0;
        cache_ready = 1'b0;
        redirect_valid = 1'b0;
        redirect_idx = '0;
        redirect_offset = '0;
        redirect_target = '0;
        commit_num = '0;
        build_table();
        rows_ready = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        cur_test = rows[0].test;
        foreach (rows[i]) begin
            @(posedge clk);
            if (rows[i].test != cur_test) begin
                report_test(cur_test);
                cur_test = rows[i].test;
            end
            pred_valid <= rows[i].pred_valid;
            pred_start_addr <= rows[i].stream.start_addr;
            pred_target <= rows[i].stream.target;
            pred_size <= rows[i].stream.size;
            cache_ready <= rows[i].cache_ready;
            redirect_valid <= rows[i].redirect_valid;
            redirect_idx <= rows[i].redirect_idx;
            redirect_offset <= rows[i].redirect_offset;
            redirect_target <= rows[i].redirect_target;
            commit_num <= rows[i].commit_num;
            // outputs settle by mid cycle
            @(negedge clk);
            check_outputs(rows[i]);
            model_step(rows[i]);
        end
        report_test(cur_test);
        $display("total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+verilog
+incdir+test
verilog/fsq_pkg.sv
verilog/fsq_ptr_if.sv
verilog/fsq_stream_ram.sv
verilog/fsq_fetch_issue.sv
verilog/fsq_commit_track.sv
verilog/fsq_tail_ctrl.sv
verilog/fsq_top.sv
test/fsq_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= fsq_tb
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
SIM ?= $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv verilog/*.svh test/*.sv test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(SIM) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG) || \
		! grep -q "Simulation completed successfully" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
